//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_music_game
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- design/beat_timer.sv
`include "game_settings.svh"

module beat_timer (
    input  logic       clock,
    input  logic       rst,
    input  logic [1:0] tempo,
    input  logic       start_beats,
    input  logic [1:0] beat_limit,
    output logic       beat_tick,
    output logic       beats_done
);

    localparam int CYC_W = $clog2(`GAME_BEAT_BASE * 4) + 1;

    logic [CYC_W-1:0] period;
    logic [CYC_W-1:0] cyc_cnt;
    logic [1:0]       beat_cnt;

    assign period    = CYC_W'(`GAME_BEAT_BASE * (tempo + 1));
    assign beat_tick = (cyc_cnt == period - CYC_W'(1));

    always_ff @(posedge clock) begin
        if (rst) begin
            cyc_cnt    <= '0;
            beat_cnt   <= '0;
            beats_done <= 1'b0;
        end else if (start_beats) begin
            // Start cycle already counts as the first of the beat
            cyc_cnt    <= CYC_W'(1);
            beat_cnt   <= '0;
            beats_done <= 1'b0;
        end else begin
            beats_done <= beat_tick && (beat_cnt == beat_limit - 2'd1);
            if (beat_tick) begin
                cyc_cnt  <= '0;
                beat_cnt <= beat_cnt + 2'd1;
            end else begin
                cyc_cnt <= cyc_cnt + CYC_W'(1);
            end
        end
    end

endmodule

//--- design/game_control.sv
`include "game_settings.svh"

module game_control (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    iniciar,
    input  logic                    cfg_ready,
    input  game_pkg::round_status_t status,
    input  logic                    note_ok,
    input  logic                    note_bad,
    input  logic                    last_in_round,
    input  logic                    beats_done,
    output game_pkg::game_ctrl_t    ctrl,
    output logic                    menu_active,
    output logic                    vez_jogador,
    output logic                    ganhou,
    output logic                    perdeu
);

    typedef enum logic [3:0] {
        MENU,
        PREPARE,
        PLAY_NOTE,
        GAP,
        PLAYER_WAIT,
        JUDGE,
        NEXT_ROUND,
        WON,
        LOST
    } state_t;

    state_t state;
    state_t next;

    always_ff @(posedge clock) begin
        if (rst)
            state <= MENU;
        else
            state <= next;
    end

    always_comb begin
        next = state;
        ctrl = '0;
        case (state)
            MENU, WON, LOST: begin
                if (iniciar && cfg_ready) begin
                    ctrl.clear_round = 1'b1;
                    ctrl.clear_idx   = 1'b1;
                    ctrl.load_lives  = 1'b1;
                    next             = PREPARE;
                end
            end
            // Also the dark cycle between played notes
            PREPARE: begin
                ctrl.show_note   = 1'b1;
                ctrl.start_beats = 1'b1;
                next             = PLAY_NOTE;
            end
            PLAY_NOTE: begin
                ctrl.show_note = !beats_done;
                if (beats_done) begin
                    if (last_in_round) begin
                        ctrl.clear_idx = 1'b1;
                        next           = GAP;
                    end else begin
                        ctrl.next_idx = 1'b1;
                        next          = PREPARE;
                    end
                end
            end
            GAP: begin
                ctrl.start_beats = 1'b1;
                next             = PLAYER_WAIT;
            end
            PLAYER_WAIT: begin
                if (note_ok) begin
                    if (last_in_round) begin
                        next = NEXT_ROUND;
                    end else begin
                        ctrl.next_idx    = 1'b1;
                        ctrl.start_beats = 1'b1;
                    end
                end else if (note_bad || beats_done) begin
                    // Wrong note or timeout, same note asked again
                    ctrl.lose_life   = 1'b1;
                    ctrl.start_beats = 1'b1;
                    next             = JUDGE;
                end
            end
            JUDGE: next = (status.lives_left == 2'd0) ? LOST : PLAYER_WAIT;
            NEXT_ROUND: begin
                if (status.round == 4'(`GAME_SONG_LEN)) begin
                    next = WON;
                end else begin
                    ctrl.next_round = 1'b1;
                    ctrl.clear_idx  = 1'b1;
                    next            = PREPARE;
                end
            end
            default: next = MENU;
        endcase
    end

    assign menu_active = (state == MENU);
    assign vez_jogador = (state == PLAYER_WAIT);
    assign ganhou      = (state == WON);
    assign perdeu      = (state == LOST);

    // End states agree with the lives counter
    assert property (@(posedge clock) disable iff (rst) perdeu |-> status.lives_left == 2'd0);
    assert property (@(posedge clock) disable iff (rst) ganhou |-> status.lives_left != 2'd0);

endmodule

//--- design/game_pkg.sv
`include "game_settings.svh"

package game_pkg;

    // One note of a song
    typedef struct packed {
        logic [`GAME_NOTE_W-1:0] note;
        logic [1:0]              beats;
    } song_entry_t;

    // Written by the menu
    typedef struct packed {
        logic [1:0] song;
        logic [1:0] tempo;
        logic [1:0] lives;
    } game_cfg_t;

    typedef enum logic [1:0] {
        MENU_SONG,
        MENU_TEMPO,
        MENU_LIVES
    } menu_item_e;

    typedef struct packed {
        logic [3:0] round;
        logic [3:0] note_idx;
        logic [1:0] lives_left;
    } round_status_t;

    // Datapath strobes from the FSM
    typedef struct packed {
        logic clear_round;
        logic next_round;
        logic clear_idx;
        logic next_idx;
        logic lose_life;
        logic load_lives;
        logic show_note;
        logic start_beats;
    } game_ctrl_t;

endpackage

//--- design/hex7seg.sv
module hex7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // Segments gfedcba, active low
    always_comb begin
        case (hexa)
            4'h0: display = 7'b1000000;
            4'h1: display = 7'b1111001;
            4'h2: display = 7'b0100100;
            4'h3: display = 7'b0110000;
            4'h4: display = 7'b0011001;
            4'h5: display = 7'b0010010;
            4'h6: display = 7'b0000010;
            4'h7: display = 7'b1111000;
            4'h8: display = 7'b0000000;
            4'h9: display = 7'b0010000;
            4'ha: display = 7'b0001000;
            4'hb: display = 7'b0000011;
            4'hc: display = 7'b1000110;
            4'hd: display = 7'b0100001;
            4'he: display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

//--- design/music_game_top.sv
`include "game_settings.svh"

module music_game_top (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      iniciar,
    input  logic                      left_pressed,
    input  logic                      right_pressed,
    input  logic                      enter_pressed,
    input  logic                      note_pressed,
    input  logic [`GAME_NOTE_W-1:0]   note_code,
    output logic                      ganhou,
    output logic                      perdeu,
    output logic                      vez_jogador,
    output logic [`GAME_NUM_LEDS-1:0] leds,
    output logic                      pulso_buzzer,
    output game_pkg::menu_item_e      menu_sel,
    output logic [6:0]                db_round,
    output logic [6:0]                db_lives,
    output logic [6:0]                db_menu
);

    game_pkg::game_cfg_t     cfg;
    game_pkg::game_ctrl_t    ctrl;
    game_pkg::round_status_t status;

    logic       cfg_ready;
    logic       menu_active;
    logic       note_ok;
    logic       note_bad;
    logic       last_in_round;
    logic       beat_tick;
    logic       beats_done;
    logic [1:0] beat_limit;
    logic [1:0] lives_shown;

    // Menu shows the chosen lives, a game the ones left
    assign lives_shown = menu_active ? cfg.lives : status.lives_left;

    settings_regs settings (
        .clock         ( clock         ),
        .rst           ( rst           ),
        .menu_active   ( menu_active   ),
        .left_pressed  ( left_pressed  ),
        .right_pressed ( right_pressed ),
        .enter_pressed ( enter_pressed ),
        .cfg           ( cfg           ),
        .cfg_ready     ( cfg_ready     ),
        .menu_sel      ( menu_sel      )
    );

    beat_timer timer (
        .clock       ( clock            ),
        .rst         ( rst              ),
        .tempo       ( cfg.tempo        ),
        .start_beats ( ctrl.start_beats ),
        .beat_limit  ( beat_limit       ),
        .beat_tick   ( beat_tick        ),
        .beats_done  ( beats_done       )
    );

    round_datapath datapath (
        .clock         ( clock         ),
        .rst           ( rst           ),
        .ctrl          ( ctrl          ),
        .cfg           ( cfg           ),
        .note_pressed  ( note_pressed  ),
        .note_code     ( note_code     ),
        .beat_tick     ( beat_tick     ),
        .status        ( status        ),
        .note_ok       ( note_ok       ),
        .note_bad      ( note_bad      ),
        .last_in_round ( last_in_round ),
        .beat_limit    ( beat_limit    ),
        .leds          ( leds          ),
        .pulso_buzzer  ( pulso_buzzer  )
    );

    game_control control (
        .clock         ( clock         ),
        .rst           ( rst           ),
        .iniciar       ( iniciar       ),
        .cfg_ready     ( cfg_ready     ),
        .status        ( status        ),
        .note_ok       ( note_ok       ),
        .note_bad      ( note_bad      ),
        .last_in_round ( last_in_round ),
        .beats_done    ( beats_done    ),
        .ctrl          ( ctrl          ),
        .menu_active   ( menu_active   ),
        .vez_jogador   ( vez_jogador   ),
        .ganhou        ( ganhou        ),
        .perdeu        ( perdeu        )
    );

    hex7seg display_round (
        .hexa    ( status.round ),
        .display ( db_round     )
    );

    hex7seg display_lives (
        .hexa    ( {2'b00, lives_shown} ),
        .display ( db_lives             )
    );

    hex7seg display_menu (
        .hexa    ( {2'b00, menu_sel} ),
        .display ( db_menu           )
    );

endmodule

//--- design/round_datapath.sv
`include "game_settings.svh"

module round_datapath (
    input  logic                      clock,
    input  logic                      rst,
    input  game_pkg::game_ctrl_t      ctrl,
    input  game_pkg::game_cfg_t       cfg,
    input  logic                      note_pressed,
    input  logic [`GAME_NOTE_W-1:0]   note_code,
    input  logic                      beat_tick,
    output game_pkg::round_status_t   status,
    output logic                      note_ok,
    output logic                      note_bad,
    output logic                      last_in_round,
    output logic [1:0]                beat_limit,
    output logic [`GAME_NUM_LEDS-1:0] leds,
    output logic                      pulso_buzzer
);

    localparam logic [`GAME_NUM_LEDS-1:0] LED_ONE = 1;

    game_pkg::song_entry_t   entry;
    logic [`GAME_NOTE_W-1:0] buzz_cnt;

    song_rom rom (
        .song  ( cfg.song        ),
        .idx   ( status.note_idx ),
        .entry ( entry           )
    );

    assign last_in_round = (status.note_idx == status.round - 4'd1);

    // Player gets one extra beat to answer
    assign beat_limit = ctrl.show_note ? entry.beats : entry.beats + 2'd1;

    always_ff @(posedge clock) begin
        if (rst) begin
            status   <= '0;
            note_ok  <= 1'b0;
            note_bad <= 1'b0;
            leds     <= '0;
        end else begin
            if (ctrl.clear_round)
                status.round <= 4'd1;
            else if (ctrl.next_round)
                status.round <= status.round + 4'd1;

            if (ctrl.clear_idx)
                status.note_idx <= '0;
            else if (ctrl.next_idx)
                status.note_idx <= status.note_idx + 4'd1;

            if (ctrl.load_lives)
                status.lives_left <= cfg.lives;
            else if (ctrl.lose_life && status.lives_left != 2'd0)
                status.lives_left <= status.lives_left - 2'd1;

            note_ok  <= note_pressed && (note_code == entry.note);
            note_bad <= note_pressed && (note_code != entry.note);
            leds     <= ctrl.show_note ? (LED_ONE << entry.note) : '0;
        end
    end

    // Square wave, half period note+2 cycles, realigned on every beat
    always_ff @(posedge clock) begin
        if (rst || !ctrl.show_note) begin
            buzz_cnt     <= '0;
            pulso_buzzer <= 1'b0;
        end else if (beat_tick) begin
            buzz_cnt <= '0;
        end else if (buzz_cnt == entry.note + 4'd1) begin
            buzz_cnt     <= '0;
            pulso_buzzer <= ~pulso_buzzer;
        end else begin
            buzz_cnt <= buzz_cnt + 4'd1;
        end
    end

    // FSM must never step the note index past the current round
    assert property (@(posedge clock) disable iff (rst) status.note_idx <= status.round);

endmodule

//--- design/settings_regs.sv
`include "game_settings.svh"

module settings_regs (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 menu_active,
    input  logic                 left_pressed,
    input  logic                 right_pressed,
    input  logic                 enter_pressed,
    output game_pkg::game_cfg_t  cfg,
    output logic                 cfg_ready,
    output game_pkg::menu_item_e menu_sel
);

    localparam logic [1:0] SONG_MAX  = 2'(`GAME_NUM_SONGS - 1);
    localparam logic [1:0] LIVES_MAX = 2'(`GAME_MAX_LIVES);

    always_ff @(posedge clock) begin
        if (rst) begin
            cfg       <= '{song: 2'd0, tempo: 2'd0, lives: LIVES_MAX};
            cfg_ready <= 1'b0;
            menu_sel  <= game_pkg::MENU_SONG;
        end else if (menu_active) begin
            if (right_pressed) begin
                case (menu_sel)
                    game_pkg::MENU_SONG:
                        cfg.song <= (cfg.song == SONG_MAX) ? 2'd0 : cfg.song + 2'd1;
                    game_pkg::MENU_TEMPO:
                        cfg.tempo <= cfg.tempo + 2'd1;
                    default:
                        cfg.lives <= (cfg.lives == LIVES_MAX) ? 2'd1 : cfg.lives + 2'd1;
                endcase
            end else if (left_pressed) begin
                case (menu_sel)
                    game_pkg::MENU_SONG:
                        cfg.song <= (cfg.song == 2'd0) ? SONG_MAX : cfg.song - 2'd1;
                    game_pkg::MENU_TEMPO:
                        cfg.tempo <= cfg.tempo - 2'd1;
                    default:
                        cfg.lives <= (cfg.lives == 2'd1) ? LIVES_MAX : cfg.lives - 2'd1;
                endcase
            end else if (enter_pressed) begin
                case (menu_sel)
                    game_pkg::MENU_SONG:  menu_sel <= game_pkg::MENU_TEMPO;
                    game_pkg::MENU_TEMPO: menu_sel <= game_pkg::MENU_LIVES;
                    default: begin
                        // Last item closes the menu
                        menu_sel  <= game_pkg::MENU_SONG;
                        cfg_ready <= 1'b1;
                    end
                endcase
            end
        end
    end

    // A game never starts with zero lives, whatever the edit sequence
    assert property (@(posedge clock) disable iff (rst) cfg.lives != 2'd0);

endmodule

//--- design/song_rom.sv
module song_rom (
    input  logic [1:0]            song,
    input  logic [3:0]            idx,
    output game_pkg::song_entry_t entry
);

    // note = (5*song + 7*idx) mod 12, two beats on odd song+idx
    always_comb begin
        case ({song, idx})
            6'h00: entry = '{4'd0, 2'd1};
            6'h01: entry = '{4'd7, 2'd2};
            6'h02: entry = '{4'd2, 2'd1};
            6'h03: entry = '{4'd9, 2'd2};
            6'h04: entry = '{4'd4, 2'd1};
            6'h05: entry = '{4'd11, 2'd2};
            6'h06: entry = '{4'd6, 2'd1};
            6'h07: entry = '{4'd1, 2'd2};
            6'h10: entry = '{4'd5, 2'd2};
            6'h11: entry = '{4'd0, 2'd1};
            6'h12: entry = '{4'd7, 2'd2};
            6'h13: entry = '{4'd2, 2'd1};
            6'h14: entry = '{4'd9, 2'd2};
            6'h15: entry = '{4'd4, 2'd1};
            6'h16: entry = '{4'd11, 2'd2};
            6'h17: entry = '{4'd6, 2'd1};
            6'h20: entry = '{4'd10, 2'd1};
            6'h21: entry = '{4'd5, 2'd2};
            6'h22: entry = '{4'd0, 2'd1};
            6'h23: entry = '{4'd7, 2'd2};
            6'h24: entry = '{4'd2, 2'd1};
            6'h25: entry = '{4'd9, 2'd2};
            6'h26: entry = '{4'd4, 2'd1};
            6'h27: entry = '{4'd11, 2'd2};
            6'h30: entry = '{4'd3, 2'd2};
            6'h31: entry = '{4'd10, 2'd1};
            6'h32: entry = '{4'd5, 2'd2};
            6'h33: entry = '{4'd0, 2'd1};
            6'h34: entry = '{4'd7, 2'd2};
            6'h35: entry = '{4'd2, 2'd1};
            6'h36: entry = '{4'd9, 2'd2};
            6'h37: entry = '{4'd4, 2'd1};
            default: entry = '{4'd0, 2'd1};
        endcase
    end

endmodule

//--- flist.f
+incdir+include
design/game_pkg.sv
design/song_rom.sv
design/settings_regs.sv
design/beat_timer.sv
design/round_datapath.sv
design/game_control.sv
design/hex7seg.sv
design/music_game_top.sv
tb/tb_music_game.sv

//--- include/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Board and game sizes
`define GAME_NUM_LEDS 12
`define GAME_SONG_LEN 8
`define GAME_NUM_SONGS 4
`define GAME_MAX_LIVES 3

// Clock cycles per beat at tempo 0, about 50 MHz / 4 on a real board
`define GAME_BEAT_BASE 8

`define GAME_NOTE_W 4

`endif

//--- tb/tb_music_game.sv
`include "game_settings.svh"

module tb_music_game;

    localparam int WAIT_LIMIT = 400;

    logic                      clock;
    logic                      rst;
    logic                      iniciar;
    logic                      left_pressed;
    logic                      right_pressed;
    logic                      enter_pressed;
    logic                      note_pressed;
    logic [`GAME_NOTE_W-1:0]   note_code;
    logic                      ganhou;
    logic                      perdeu;
    logic                      vez_jogador;
    logic [`GAME_NUM_LEDS-1:0] leds;
    logic                      pulso_buzzer;
    game_pkg::menu_item_e      menu_sel;
    logic [6:0]                db_round;
    logic [6:0]                db_lives;
    logic [6:0]                db_menu;

    int song_sel;
    int tempo_sel;
    int lives_cfg;
    int lives_exp;
    int rand_init;

    music_game_top dut_i (
        .clock         ( clock         ),
        .rst           ( rst           ),
        .iniciar       ( iniciar       ),
        .left_pressed  ( left_pressed  ),
        .right_pressed ( right_pressed ),
        .enter_pressed ( enter_pressed ),
        .note_pressed  ( note_pressed  ),
        .note_code     ( note_code     ),
        .ganhou        ( ganhou        ),
        .perdeu        ( perdeu        ),
        .vez_jogador   ( vez_jogador   ),
        .leds          ( leds          ),
        .pulso_buzzer  ( pulso_buzzer  ),
        .menu_sel      ( menu_sel      ),
        .db_round      ( db_round      ),
        .db_lives      ( db_lives      ),
        .db_menu       ( db_menu       )
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Song table reference
    function automatic int ref_note(input int s, input int i);
        return (5 * s + 7 * i) % 12;
    endfunction

    function automatic int ref_beats(input int s, input int i);
        return ((s + i) % 2 == 0) ? 1 : 2;
    endfunction

    function automatic int beat_len();
        return `GAME_BEAT_BASE * (tempo_sel + 1);
    endfunction

    // Active low gfedcba
    function automatic logic [6:0] seg_digit(input int d);
        case (d)
            0: return 7'h40;
            1: return 7'h79;
            2: return 7'h24;
            3: return 7'h30;
            4: return 7'h19;
            5: return 7'h12;
            6: return 7'h02;
            7: return 7'h78;
            8: return 7'h00;
            default: return 7'h7f;
        endcase
    endfunction

    // Any code from 0 to 11 except the right one
    function automatic int wrong_code(input int note);
        return (note + 1 + int'($urandom % 11)) % 12;
    endfunction

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_wait(input int count, input string what);
        assert (count <= WAIT_LIMIT) else begin
            $display("timeout after %0d cycles waiting for %s", count, what);
            stop_with_failure();
        end
    endtask

    task automatic menu_key(input logic l, input logic r, input logic e);
        @(posedge clock);
        left_pressed  <= l;
        right_pressed <= r;
        enter_pressed <= e;
        @(posedge clock);
        left_pressed  <= 1'b0;
        right_pressed <= 1'b0;
        enter_pressed <= 1'b0;
        @(negedge clock);
    endtask

    task automatic pulse_iniciar();
        @(posedge clock);
        iniciar <= 1'b1;
        @(posedge clock);
        iniciar <= 1'b0;
        @(negedge clock);
    endtask

    task automatic start_game();
        pulse_iniciar();
        lives_exp = lives_cfg;
        check_value("ganhou", int'(ganhou), 0);
        check_value("perdeu", int'(perdeu), 0);
        check_value("db_lives", int'(db_lives), int'(seg_digit(lives_exp)));
    endtask

    task automatic press_note(input int code);
        @(posedge clock);
        note_pressed <= 1'b1;
        note_code    <= `GAME_NOTE_W'(code);
        @(posedge clock);
        note_pressed <= 1'b0;
        @(posedge clock);
    endtask

    task automatic wait_turn();
        int n;
        n = 0;
        @(negedge clock);
        while (!vez_jogador) begin
            @(negedge clock);
            n++;
            check_wait(n, "vez_jogador");
        end
        check_value("leds", int'(leds), 0);
        check_value("pulso_buzzer", int'(pulso_buzzer), 0);
    endtask

    // Checks every played note of round r, returns at the start of the turn
    task automatic play_round(input int r);
        logic [`GAME_NUM_LEDS-1:0] expected;
        int i;
        int n;
        int len;
        for (i = 0; i < r; i++) begin
            expected = '0;
            expected[ref_note(song_sel, i)] = 1'b1;
            n = 0;
            @(negedge clock);
            while (leds == '0) begin
                @(negedge clock);
                n++;
                check_wait(n, "a note on leds");
            end
            if (i > 0)
                check_value("dark cycles between notes", n + 1, 1);
            check_value("leds", int'(leds), int'(expected));
            check_value("vez_jogador", int'(vez_jogador), 0);
            check_value("db_round", int'(db_round), int'(seg_digit(r)));
            len = 0;
            while (leds == expected) begin
                len++;
                check_wait(len, "the note to end");
                @(negedge clock);
            end
            check_value("note length", len, ref_beats(song_sel, i) * beat_len());
            check_value("leds", int'(leds), 0);
        end
        wait_turn();
    endtask

    task automatic wait_lives_drop();
        int n;
        n = 0;
        @(negedge clock);
        while (db_lives == seg_digit(lives_exp)) begin
            @(negedge clock);
            n++;
            check_wait(n, "db_lives to change");
        end
        lives_exp--;
        check_value("db_lives", int'(db_lives), int'(seg_digit(lives_exp)));
    endtask

    task automatic wait_game_over(input logic want_win);
        int n;
        n = 0;
        @(negedge clock);
        while (!(ganhou || perdeu)) begin
            @(negedge clock);
            n++;
            check_wait(n, "the end of the game");
        end
        // Result must hold until the next start
        for (n = 0; n < 10; n++) begin
            check_value("ganhou", int'(ganhou), int'(want_win));
            check_value("perdeu", int'(perdeu), int'(!want_win));
            check_value("vez_jogador", int'(vez_jogador), 0);
            @(negedge clock);
        end
    endtask

    task automatic test_after_reset();
        int n;
        @(negedge clock);
        check_value("ganhou", int'(ganhou), 0);
        check_value("perdeu", int'(perdeu), 0);
        check_value("vez_jogador", int'(vez_jogador), 0);
        check_value("leds", int'(leds), 0);
        check_value("pulso_buzzer", int'(pulso_buzzer), 0);
        check_value("menu_sel", int'(menu_sel), int'(game_pkg::MENU_SONG));
        check_value("db_menu", int'(db_menu), int'(seg_digit(0)));
        check_value("db_round", int'(db_round), int'(seg_digit(0)));
        // Menu not done yet, so no game starts
        pulse_iniciar();
        for (n = 0; n < 20; n++) begin
            check_value("leds", int'(leds), 0);
            check_value("vez_jogador", int'(vez_jogador), 0);
            @(negedge clock);
        end
    endtask

    task automatic test_menu();
        int n;
        song_sel = int'($urandom % 4);
        menu_key(1'b1, 1'b0, 1'b0);
        menu_key(1'b0, 1'b1, 1'b0);
        for (n = 0; n < song_sel; n++)
            menu_key(1'b0, 1'b1, 1'b0);
        check_value("menu_sel", int'(menu_sel), int'(game_pkg::MENU_SONG));
        menu_key(1'b0, 1'b0, 1'b1);
        check_value("menu_sel", int'(menu_sel), int'(game_pkg::MENU_TEMPO));
        check_value("db_menu", int'(db_menu), int'(seg_digit(1)));
        // Tempo 0 wraps down to 3 and back up, ends at 1
        menu_key(1'b1, 1'b0, 1'b0);
        menu_key(1'b0, 1'b1, 1'b0);
        menu_key(1'b0, 1'b1, 1'b0);
        tempo_sel = 1;
        menu_key(1'b0, 1'b0, 1'b1);
        check_value("menu_sel", int'(menu_sel), int'(game_pkg::MENU_LIVES));
        check_value("db_menu", int'(db_menu), int'(seg_digit(2)));
        check_value("db_lives", int'(db_lives), int'(seg_digit(3)));
        menu_key(1'b0, 1'b1, 1'b0);
        check_value("db_lives", int'(db_lives), int'(seg_digit(1)));
        menu_key(1'b1, 1'b0, 1'b0);
        check_value("db_lives", int'(db_lives), int'(seg_digit(3)));
        menu_key(1'b1, 1'b0, 1'b0);
        check_value("db_lives", int'(db_lives), int'(seg_digit(2)));
        menu_key(1'b0, 1'b1, 1'b0);
        check_value("db_lives", int'(db_lives), int'(seg_digit(3)));
        lives_cfg = `GAME_MAX_LIVES;
        menu_key(1'b0, 1'b0, 1'b1);
        check_value("menu_sel", int'(menu_sel), int'(game_pkg::MENU_SONG));
    endtask

    task automatic test_winning();
        int r;
        int i;
        start_game();
        for (r = 1; r <= `GAME_SONG_LEN; r++) begin
            play_round(r);
            for (i = 0; i < r; i++) begin
                if (i > 0)
                    wait_turn();
                press_note(ref_note(song_sel, i));
            end
        end
        wait_game_over(1'b1);
        check_value("db_round", int'(db_round), int'(seg_digit(`GAME_SONG_LEN)));
        check_value("db_lives", int'(db_lives), int'(seg_digit(lives_cfg)));
    endtask

    task automatic test_wrong_notes();
        start_game();
        play_round(1);
        press_note(wrong_code(ref_note(song_sel, 0)));
        wait_lives_drop();
        wait_turn();
        // Same note still expected, round 2 follows
        press_note(ref_note(song_sel, 0));
        play_round(2);
        press_note(ref_note(song_sel, 0));
        wait_turn();
        press_note(wrong_code(ref_note(song_sel, 1)));
        wait_lives_drop();
        wait_turn();
        press_note(wrong_code(ref_note(song_sel, 1)));
        wait_lives_drop();
        wait_game_over(1'b0);
    endtask

    task automatic test_timeout();
        int n;
        start_game();
        play_round(1);
        n = 0;
        while (db_lives == seg_digit(lives_exp)) begin
            @(negedge clock);
            n++;
            check_wait(n, "the turn to time out");
        end
        check_value("timeout cycles", n, (ref_beats(song_sel, 0) + 1) * beat_len());
        lives_exp--;
        check_value("db_lives", int'(db_lives), int'(seg_digit(lives_exp)));
        wait_turn();
        press_note(ref_note(song_sel, 0));
        play_round(2);
    endtask

    initial begin
        rst           <= 1'b1;
        iniciar       <= 1'b0;
        left_pressed  <= 1'b0;
        right_pressed <= 1'b0;
        enter_pressed <= 1'b0;
        note_pressed  <= 1'b0;
        note_code     <= '0;
        rand_init = int'($urandom(32'ha33b_c66f));
        repeat (8) @(posedge clock);
        rst <= 1'b0;
        test_after_reset();
        test_menu();
        test_winning();
        test_wrong_notes();
        test_timeout();
        $display("Finished with no errors");
        $finish;
    end

endmodule
